// ==== soc_mem_harness.f ====
+incdir+include
logic/soc_mem_pkg.sv
logic/mem_port_if.sv
logic/mem_router.sv
logic/boot_rom.sv
logic/sram_bank.sv
logic/rsp_merge.sv
logic/soc_mem_harness.sv
test/tb_soc_mem_harness.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the SoC memory harness testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f soc_mem_harness.f \
  --top-module tb_soc_mem_harness \
  -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Errors found" "$LOG_FILE"; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== test/soc_mem_stimulus.txt ====
// Columns mode_we_addr_wdata_be_rdata_err_exit in hex, rdata and err are the expected response
// mode 1 holds rsp_ready_i high, 0 takes it from the LFSR, F ends; exit 1 checks exit_o = wdata
// ROM reads with ready held high
1_0_00010000_0000000000000000_00_B00700004FF8FFFF_0_0
1_0_00010028_0000000000000000_00_B00700054FF8FFFA_0_0
1_0_000101F8_0000000000000000_00_B007003F4FF8FFC0_0_0
1_0_0001000F_0000000000000000_00_B00700014FF8FFFE_0_0
1_0_00010100_0000000000000000_00_B00700204FF8FFDF_0_0
// SRAM writes with partial byte enables, then reads
1_1_80000000_1122334455667788_FF_0000000000000000_0_0
1_1_80000000_AAAAAAAAAAAAAAAA_0F_0000000000000000_0_0
1_0_80000000_0000000000000000_00_11223344AAAAAAAA_0_0
1_1_80000008_0123456789ABCDEF_FF_0000000000000000_0_0
1_1_80000008_FFFFFFFFFFFFFFFF_81_0000000000000000_0_0
1_0_80000008_0000000000000000_00_FF23456789ABCDFF_0_0
1_1_800007F0_CAFEF00DDEADBEEF_FF_0000000000000000_0_0
1_1_800007F0_0000000000000000_3C_0000000000000000_0_0
1_0_800007F0_0000000000000000_00_CAFE00000000BEEF_0_0
// ROM write and unmapped accesses, then normal accesses again
1_1_00010000_0000000000001234_FF_0000000000000000_1_0
1_0_00000000_0000000000000000_00_0000000000000000_1_0
1_0_00010200_0000000000000000_00_0000000000000000_1_0
1_1_80000800_5A5A5A5A5A5A5A5A_FF_0000000000000000_1_0
1_0_7FFFFFF8_0000000000000000_00_0000000000000000_1_0
1_0_00010008_0000000000000000_00_B00700014FF8FFFE_0_0
1_0_80000000_0000000000000000_00_11223344AAAAAAAA_0_0
// Random back-pressure on the response side
0_1_80000010_0F0F0F0F0F0F0F0F_FF_0000000000000000_0_0
0_0_00010010_0000000000000000_00_B00700024FF8FFFD_0_0
0_0_80000010_0000000000000000_00_0F0F0F0F0F0F0F0F_0_0
0_1_80000010_F0F0F0F0F0F0F0F0_F0_0000000000000000_0_0
0_0_40000000_0000000000000000_00_0000000000000000_1_0
0_0_80000010_0000000000000000_00_F0F0F0F00F0F0F0F_0_0
0_0_80000008_0000000000000000_00_FF23456789ABCDFF_0_0
0_1_80000018_5555AAAA5555AAAA_FF_0000000000000000_0_0
0_0_80000018_0000000000000000_00_5555AAAA5555AAAA_0_0
0_0_000101F0_0000000000000000_00_B007003E4FF8FFC1_0_0
0_1_00010040_1111111111111111_0F_0000000000000000_1_0
0_0_800007F0_0000000000000000_00_CAFE00000000BEEF_0_0
// Exit register word
0_1_800007F8_00000000000000A5_FF_0000000000000000_0_1
0_0_800007F8_0000000000000000_00_00000000000000A5_0_0
0_0_80000000_0000000000000000_00_11223344AAAAAAAA_0_0
0_1_800007F8_DEADBEEF00000001_FF_0000000000000000_0_1
0_0_800007F8_0000000000000000_00_DEADBEEF00000001_0_0
// End marker
F_0_00000000_0000000000000000_00_0000000000000000_0_0

// ==== test/tb_soc_mem_harness.sv ====
`default_nettype none

`include "soc_mem_macros.svh"

module tb_soc_mem_harness;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_LINES       = 128;
  localparam int LINE_W          = 184;
  localparam int CYCLES_PER_LINE = 20;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_valid_i;
  logic                   req_ready_o;
  logic                   req_we_i;
  logic [`SOC_ADDR_W-1:0] req_addr_i;
  logic [`SOC_DATA_W-1:0] req_wdata_i;
  logic [`SOC_BE_W-1:0]   req_be_i;
  logic                   rsp_valid_o;
  logic                   rsp_ready_i;
  logic [`SOC_DATA_W-1:0] rsp_rdata_o;
  logic                   rsp_err_o;
  logic [`SOC_DATA_W-1:0] exit_o;

  // Raw stimulus lines and their fields
  logic [LINE_W-1:0]      stim_mem [MAX_LINES];
  logic                   hold_ready_a [MAX_LINES];
  logic                   we_a [MAX_LINES];
  logic [`SOC_ADDR_W-1:0] addr_a [MAX_LINES];
  logic [`SOC_DATA_W-1:0] wdata_a [MAX_LINES];
  logic [`SOC_BE_W-1:0]   be_a [MAX_LINES];
  logic [`SOC_DATA_W-1:0] exp_rdata_a [MAX_LINES];
  logic                   exp_err_a [MAX_LINES];
  logic                   exit_flag_a [MAX_LINES];

  int          n_lines;
  int          sent;
  int          cycles;
  int          timeout_limit;
  int          checks;
  int          errors;
  bit          timed_out;
  logic [31:0] lfsr;
  int          exp_q [$];

  soc_mem_harness uut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_we_i    ( req_we_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_be_i    ( req_be_i    ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .exit_o      ( exit_o      )
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic load_stimulus();
    bit stop;
    bit found;
    stop    = 1'b0;
    found   = 1'b0;
    n_lines = 0;
    $readmemh("test/soc_mem_stimulus.txt", stim_mem);
    for (int i = 0; i < MAX_LINES && !stop; i++) begin
      if ($isunknown(stim_mem[i])) begin
        stop = 1'b1;
      end else if (stim_mem[i][183:180] == 4'hF) begin
        stop  = 1'b1;
        found = 1'b1;
      end else begin
        hold_ready_a[i] = stim_mem[i][180];
        we_a[i]         = stim_mem[i][176];
        addr_a[i]       = stim_mem[i][175:144];
        wdata_a[i]      = stim_mem[i][143:80];
        be_a[i]         = stim_mem[i][79:72];
        exp_rdata_a[i]  = stim_mem[i][71:8];
        exp_err_a[i]    = stim_mem[i][4];
        exit_flag_a[i]  = stim_mem[i][0];
        n_lines++;
      end
    end
    checks++;
    assert (found && n_lines > 0) else begin
      errors++;
      $display("Stimulus file is incomplete or holds no requests");
      n_lines = 0;
    end
  endtask

  task automatic drive_request(input int idx);
    req_valid_i = 1'b1;
    req_we_i    = we_a[idx];
    req_addr_i  = addr_a[idx];
    req_wdata_i = wdata_a[idx];
    req_be_i    = be_a[idx];
  endtask

  task automatic drive_idle();
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_be_i    = '0;
  endtask

  // Ready follows the line now being driven, or the last line once all are sent
  task automatic pick_ready();
    int idx;
    idx = (sent < n_lines) ? sent : n_lines - 1;
    if (hold_ready_a[idx]) begin
      rsp_ready_i = 1'b1;
    end else begin
      lfsr        = lfsr_next(lfsr);
      rsp_ready_i = lfsr[0];
    end
  endtask

  // --------------------------------------------------
  // Traffic loop sampling at the falling edge
  // --------------------------------------------------
  task automatic run_traffic();
    int pending;
    int line;
    bit req_fire;
    bit rsp_fire;
    while ((sent < n_lines || exp_q.size() != 0) && !timed_out) begin
      @(negedge clk_i);
      pending  = exp_q.size();
      req_fire = req_valid_i && req_ready_o;
      rsp_fire = rsp_valid_o && rsp_ready_i;
      // Two slots shared by queued and in-flight responses
      check_value("req_ready_o", 64'(req_ready_o),
                  64'((pending - int'(rsp_fire)) < 2));
      checks++;
      assert (!(rsp_valid_o && pending == 0)) else begin
        errors++;
        $display("%0t Response valid with no request outstanding", $time);
      end
      if (rsp_fire && pending != 0) begin
        line = exp_q.pop_front();
        check_value("rsp_rdata_o", rsp_rdata_o, exp_rdata_a[line]);
        check_value("rsp_err_o", 64'(rsp_err_o), 64'(exp_err_a[line]));
        if (exit_flag_a[line]) begin
          check_value("exit_o", exit_o, wdata_a[line]);
        end
      end
      if (req_fire) begin
        exp_q.push_back(sent);
        sent++;
      end
      @(posedge clk_i);
      #1;
      if (req_fire) begin
        if (sent < n_lines) begin
          drive_request(sent);
        end else begin
          drive_idle();
        end
      end
      pick_ready();
      cycles++;
      if (cycles >= timeout_limit) begin
        timed_out = 1'b1;
        errors++;
        $display("Timeout after %0d cycles with %0d of %0d requests sent", cycles, sent,
                 n_lines);
      end
    end
  endtask

  initial begin
    rst_ni      = 1'b0;
    rsp_ready_i = 1'b0;
    drive_idle();
    lfsr      = 32'hf39f0f6f;
    sent      = 0;
    cycles    = 0;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    load_stimulus();
    timeout_limit = n_lines * CYCLES_PER_LINE;

    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    @(negedge clk_i);
    check_value("rsp_valid_o", 64'(rsp_valid_o), 64'(1'b0));
    check_value("exit_o", exit_o, '0);
    check_value("req_ready_o", 64'(req_ready_o), 64'(1'b1));

    @(posedge clk_i);
    #1;
    if (n_lines > 0) begin
      drive_request(0);
      pick_ready();
      run_traffic();
    end
    drive_idle();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/soc_mem_harness.sv ====
`default_nettype none

`include "soc_mem_macros.svh"

module soc_mem_harness (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Request side
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  logic                   req_we_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  input  logic [`SOC_BE_W-1:0]   req_be_i,
  // Response side
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output logic [`SOC_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic [`SOC_DATA_W-1:0] exit_o
);

  import soc_mem_pkg::*;

  logic    issue;
  target_e issue_tgt;
  logic    credit;
  rsp_t    rsp;

  mem_port_if #(.IDX_W($clog2(`SOC_ROM_WORDS))) rom_port ();
  mem_port_if #(.IDX_W($clog2(`SOC_RAM_WORDS))) ram_port ();

  // --------------------------------------------------
  // Request path
  // --------------------------------------------------
  mem_router u_router (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_we_i    ( req_we_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .req_be_i    ( req_be_i    ),
    .req_ready_o ( req_ready_o ),
    .credit_i    ( credit      ),
    .issue_o     ( issue       ),
    .issue_tgt_o ( issue_tgt   ),
    .rom_o       ( rom_port    ),
    .ram_o       ( ram_port    )
  );

  // --------------------------------------------------
  // Targets
  // --------------------------------------------------
  boot_rom u_rom (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .port_i ( rom_port )
  );

  sram_bank u_ram (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .port_i ( ram_port ),
    .exit_o ( exit_o   )
  );

  // --------------------------------------------------
  // Response path
  // --------------------------------------------------
  rsp_merge u_merge (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .issue_i     ( issue          ),
    .issue_tgt_i ( issue_tgt      ),
    .rom_rdata_i ( rom_port.rdata ),
    .ram_rdata_i ( ram_port.rdata ),
    .credit_o    ( credit         ),
    .rsp_valid_o ( rsp_valid_o    ),
    .rsp_ready_i ( rsp_ready_i    ),
    .rsp_o       ( rsp            )
  );

  assign rsp_rdata_o = rsp.rdata;
  assign rsp_err_o   = rsp.err;

endmodule

`default_nettype wire

// ==== logic/rsp_merge.sv ====
`default_nettype none

`include "soc_mem_macros.svh"

module rsp_merge (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   issue_i,
  input  soc_mem_pkg::target_e   issue_tgt_i,
  input  logic [`SOC_DATA_W-1:0] rom_rdata_i,
  input  logic [`SOC_DATA_W-1:0] ram_rdata_i,
  output logic                   credit_o,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output soc_mem_pkg::rsp_t      rsp_o
);

  import soc_mem_pkg::*;

  localparam int unsigned DEPTH = `SOC_RSP_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic             inflight_q;
  target_e          inflight_tgt_q;
  rsp_t             push_rsp;
  logic             push;
  logic             pop;
  rsp_t             queue_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W:0]   occupancy;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // --------------------------------------------------
  // In-flight stage
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q     <= 1'b0;
      inflight_tgt_q <= TGT_ERR;
    end else begin
      inflight_q <= issue_i;
      if (issue_i) begin
        inflight_tgt_q <= issue_tgt_i;
      end
    end
  end

  // Target data is valid one cycle after its strobe
  always_comb begin
    push_rsp = '0;
    unique case (inflight_tgt_q)
      TGT_ROM: push_rsp.rdata = rom_rdata_i;
      TGT_RAM: push_rsp.rdata = ram_rdata_i;
      default: push_rsp.err = 1'b1;
    endcase
  end

  assign push = inflight_q;
  assign pop  = rsp_valid_o & rsp_ready_i;

  // --------------------------------------------------
  // Response queue
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= push_rsp;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign rsp_valid_o = (count_q != '0);
  assign rsp_o       = queue_q[rd_ptr_q];

  // A slot freed by this cycle's pop can be granted again
  assign occupancy = (CNT_W + 1)'(count_q) + (CNT_W + 1)'(inflight_q) - (CNT_W + 1)'(pop);
  assign credit_o  = (occupancy < (CNT_W + 1)'(DEPTH));

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> (count_q < CNT_W'(DEPTH)));

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)));

endmodule

`default_nettype wire

// ==== logic/sram_bank.sv ====
`default_nettype none

`include "soc_mem_macros.svh"

module sram_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  mem_port_if.target             port_i,
  output logic [`SOC_DATA_W-1:0] exit_o
);

  localparam int unsigned RAM_IDX_W = $clog2(`SOC_RAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_RAM_WORDS];
  logic [`SOC_DATA_W-1:0] old_word;
  logic [`SOC_DATA_W-1:0] merged_word;
  logic                   wr_en;
  logic                   exit_hit;

  assign old_word = mem_q[port_i.idx];
  assign wr_en    = port_i.req & port_i.we;
  assign exit_hit = (port_i.idx == RAM_IDX_W'(`SOC_EXIT_IDX));

  // Byte lanes from wdata where enabled, old contents elsewhere
  always_comb begin
    for (int b = 0; b < `SOC_BE_W; b++) begin
      merged_word[b*8 +: 8] = port_i.be[b] ? port_i.wdata[b*8 +: 8] : old_word[b*8 +: 8];
    end
  end

  // --------------------------------------------------
  // Storage and read port
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[port_i.idx] <= merged_word;
    end
  end

  // Write responses carry zero data
  always_ff @(posedge clk_i) begin
    if (port_i.req) begin
      port_i.rdata <= port_i.we ? '0 : old_word;
    end
  end

  // --------------------------------------------------
  // Exit register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_o <= '0;
    end else if (wr_en && exit_hit) begin
      exit_o <= merged_word;
    end
  end

  a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en |-> (port_i.be != '0));

endmodule

`default_nettype wire

// ==== logic/boot_rom.sv ====
`default_nettype none

`include "soc_mem_macros.svh"

module boot_rom (
  input  logic      clk_i,
  input  logic      rst_ni,
  mem_port_if.target port_i
);

  localparam int unsigned HALF_W = `SOC_DATA_W / 2;

  logic [`SOC_DATA_W-1:0] rom_words [`SOC_ROM_WORDS];

  // --------------------------------------------------
  // Fixed contents
  // --------------------------------------------------
  // Upper half is tag plus index, lower half its inverse
  for (genvar i = 0; i < `SOC_ROM_WORDS; i++) begin : g_words
    localparam logic [HALF_W-1:0] HI = HALF_W'(`SOC_ROM_TAG + i);
    assign rom_words[i] = {HI, ~HI};
  end

  // --------------------------------------------------
  // Registered read
  // --------------------------------------------------
  // Holds the last word read until the next strobe
  always_ff @(posedge clk_i) begin
    if (port_i.req) begin
      port_i.rdata <= rom_words[port_i.idx];
    end
  end

  // The router answers ROM writes itself
  a_no_rom_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    port_i.req |-> !port_i.we);

endmodule

`default_nettype wire

// ==== logic/mem_router.sv ====
`default_nettype none

`include "soc_mem_macros.svh"

module mem_router (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_valid_i,
  input  logic                      req_we_i,
  input  logic [`SOC_ADDR_W-1:0]    req_addr_i,
  input  logic [`SOC_DATA_W-1:0]    req_wdata_i,
  input  logic [`SOC_BE_W-1:0]      req_be_i,
  output logic                      req_ready_o,
  input  logic                      credit_i,
  output logic                      issue_o,
  output soc_mem_pkg::target_e      issue_tgt_o,
  mem_port_if.router                rom_o,
  mem_port_if.router                ram_o
);

  import soc_mem_pkg::*;

  localparam int unsigned OFS_W      = $clog2(`SOC_BE_W);
  localparam int unsigned ROM_IDX_W  = $clog2(`SOC_ROM_WORDS);
  localparam int unsigned RAM_IDX_W  = $clog2(`SOC_RAM_WORDS);
  localparam logic [`SOC_ADDR_W-1:0] ROM_SPAN = `SOC_ADDR_W'(`SOC_ROM_WORDS * `SOC_BE_W);
  localparam logic [`SOC_ADDR_W-1:0] RAM_SPAN = `SOC_ADDR_W'(`SOC_RAM_WORDS * `SOC_BE_W);

  logic [`SOC_ADDR_W-1:0] rom_off;
  logic [`SOC_ADDR_W-1:0] ram_off;
  logic                   accept;
  target_e                tgt;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  // Offsets below the base wrap to large values and miss the window
  assign rom_off = req_addr_i - `SOC_ROM_BASE;
  assign ram_off = req_addr_i - `SOC_RAM_BASE;

  always_comb begin
    if (rom_off < ROM_SPAN && !req_we_i) begin
      tgt = TGT_ROM;
    end else if (ram_off < RAM_SPAN) begin
      tgt = TGT_RAM;
    end else begin
      // Unmapped, or a write into ROM
      tgt = TGT_ERR;
    end
  end

  // --------------------------------------------------
  // Acceptance and issue
  // --------------------------------------------------
  assign req_ready_o = credit_i;
  assign accept      = req_valid_i & credit_i;
  assign issue_o     = accept;
  assign issue_tgt_o = tgt;

  assign rom_o.req   = accept && (tgt == TGT_ROM);
  assign rom_o.we    = req_we_i;
  assign rom_o.idx   = rom_off[OFS_W +: ROM_IDX_W];
  assign rom_o.wdata = req_wdata_i;
  assign rom_o.be    = req_be_i;

  assign ram_o.req   = accept && (tgt == TGT_RAM);
  assign ram_o.we    = req_we_i;
  assign ram_o.idx   = ram_off[OFS_W +: RAM_IDX_W];
  assign ram_o.wdata = req_wdata_i;
  assign ram_o.be    = req_be_i;

  // At most one target sees a strobe per cycle
  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rom_o.req && ram_o.req));

endmodule

`default_nettype wire

// ==== logic/mem_port_if.sv ====
`default_nettype none

`include "soc_mem_macros.svh"

// Router to memory target with a single-cycle strobe and registered read data
interface mem_port_if #(
  parameter int unsigned IDX_W = 8
);

  logic                   req;
  logic                   we;
  logic [IDX_W-1:0]       idx;
  logic [`SOC_DATA_W-1:0] wdata;
  logic [`SOC_BE_W-1:0]   be;
  logic [`SOC_DATA_W-1:0] rdata;

  modport router (
    output req,
    output we,
    output idx,
    output wdata,
    output be,
    input  rdata
  );

  modport target (
    input  req,
    input  we,
    input  idx,
    input  wdata,
    input  be,
    output rdata
  );

endinterface

`default_nettype wire

// ==== logic/soc_mem_pkg.sv ====
`default_nettype none

`include "soc_mem_macros.svh"

package soc_mem_pkg;

  // Where an accepted request was sent
  typedef enum logic [1:0] {
    TGT_ROM = 2'd0,
    TGT_RAM = 2'd1,
    TGT_ERR = 2'd2
  } target_e;

  // One entry of the response stream
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   err;
  } rsp_t;

endpackage

`default_nettype wire

// ==== include/soc_mem_macros.svh ====
`ifndef SOC_MEM_MACROS_SVH
`define SOC_MEM_MACROS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define SOC_DATA_W 64
`define SOC_ADDR_W 32
`define SOC_BE_W 8

// --------------------------------------------------
// Address map
// --------------------------------------------------
// Boot ROM with 64 words of 8 bytes
`define SOC_ROM_BASE 32'h0001_0000
`define SOC_ROM_WORDS 64

// SRAM bank with 256 words of 8 bytes
`define SOC_RAM_BASE 32'h8000_0000
`define SOC_RAM_WORDS 256

// Exit register word at byte address 32'h8000_07F8
`define SOC_EXIT_IDX 255

// Upper half of every ROM word starts from this tag
`define SOC_ROM_TAG 32'hB007_0000

// Response queue entries
`define SOC_RSP_DEPTH 2

`endif
